/* list.f */
verilog/sampleFormatPkg.sv
verilog/captureStatePkg.sv
verilog/asyncFifo.sv
verilog/captureControl.sv
verilog/byteSerializer.sv
verilog/dataStorage.sv
bench/dataStorageBench.sv

/* Makefile */
# Verilator build and run for the capture buffer testbench

VERILATOR ?= verilator
TOP ?= dataStorageBench
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test completed successfully

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILE_LIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/dataStorageBench.sv */
`timescale 1ns/100ps

// Testbench for the dual-clock capture buffer
module dataStorageBench;

	// Small FIFO so one capture can fill it
	localparam int FifoDepth = 4;
	localparam int CaptureDepth = FifoDepth;
	localparam int BytesPerCapture = CaptureDepth * sampleFormatPkg::LaneCount;
	localparam int WaitLimit = 400;
	localparam int QuietCycles = 40;

	// Clocks and DUT ports
	logic ReadClock = 1'b0;
	logic WriteClock = 1'b0;
	logic rstN;
	logic writeStrobe;
	logic dataAck;
	sampleFormatPkg::sampleWord dataIn = '0;
	sampleFormatPkg::laneByte dataOut;
	logic dataReq;
	logic dataReadyToSend;
	logic fifoNotFull;
	captureStatePkg::captureState state;

	// Ramp, random seed and bookkeeping
	logic [7:0] ramp = 8'd0;
	integer seed = 32'ha164_bbe2;
	int valueErrors = 0;
	int protocolErrors = 0;
	int reqCount = 0;
	int fullCount = 0;
	logic reqLast = 1'b0;
	bit strobeSent = 1'b0;
	bit timedOut = 1'b0;
	int testsRun = 0;
	int testsFailed = 0;

	dataStorage #(
		.FifoDepth    (FifoDepth),
		.CaptureDepth (CaptureDepth)
	) u_dataStorage (
		.WriteClock      (WriteClock),
		.dataIn          (dataIn),
		.writeStrobe     (writeStrobe),
		.ReadClock       (ReadClock),
		.rstN            (rstN),
		.dataAck         (dataAck),
		.dataOut         (dataOut),
		.dataReq         (dataReq),
		.dataReadyToSend (dataReadyToSend),
		.fifoNotFull     (fifoNotFull),
		.state           (state)
	);

	// Host clock 10 ns and sampler clock 4 ns
	always #5 ReadClock = ~ReadClock;
	always #2 WriteClock = ~WriteClock;

	// Word for ramp value n
	// DI n+3, DID n+1, DQ n+2, DQD n
	function automatic sampleFormatPkg::sampleWord rampWord(input logic [7:0] n);
		return {n + 8'd3, n + 8'd1, n + 8'd2, n};
	endfunction

	// Byte offset from the group base with the lowest lane first
	function automatic int laneOffset(input int lane);
		case (lane)
			0: return 0;
			1: return 2;
			2: return 1;
			default: return 3;
		endcase
	endfunction

	// Sampler model stepping by 4 on each write edge
	always @(negedge WriteClock) begin
		ramp <= ramp + 8'd4;
		dataIn <= rampWord(ramp + 8'd4);
	end

	// Counts handshaken bytes and cycles with the FIFO full
	always @(posedge ReadClock) begin
		reqLast <= dataReq;
		if (rstN && dataReq && !reqLast) reqCount <= reqCount + 1;
		if (rstN && !fifoNotFull) fullCount <= fullCount + 1;
	end

	//////////////////////////////////////////////////
	// Protocol checks
	//////////////////////////////////////////////////

	idleUntilStrobe: assert property (@(posedge ReadClock) disable iff (!rstN)
		!strobeSent |-> (!dataReq && !dataReadyToSend && fifoNotFull
			&& state == captureStatePkg::Idle)
	) else begin
		$display("[FAIL] %0t outputs left reset values before any strobe", $time);
		protocolErrors = protocolErrors + 1;
	end

	holdWhileReq: assert property (@(posedge ReadClock) disable iff (!rstN)
		dataReq && $past(dataReq) |-> $stable(dataOut)
	) else begin
		$display("[FAIL] %0t dataOut changed while dataReq high", $time);
		protocolErrors = protocolErrors + 1;
	end

	// Next request only after ack is low again
	reqAfterAckLow: assert property (@(posedge ReadClock) disable iff (!rstN)
		$rose(dataReq) |-> !$past(dataAck)
	) else begin
		$display("[FAIL] %0t dataReq rose while dataAck high", $time);
		protocolErrors = protocolErrors + 1;
	end

	reqDropsOnAck: assert property (@(posedge ReadClock) disable iff (!rstN)
		$fell(dataReq) |-> $past(dataAck)
	) else begin
		$display("[FAIL] %0t dataReq fell without dataAck", $time);
		protocolErrors = protocolErrors + 1;
	end

	readyMatchesState: assert property (@(posedge ReadClock) disable iff (!rstN)
		dataReadyToSend == (state == captureStatePkg::Draining
			|| state == captureStatePkg::Sending)
	) else begin
		$display("[FAIL] %0t dataReadyToSend %b in state %0d",
			$time, dataReadyToSend, state);
		protocolErrors = protocolErrors + 1;
	end

	//////////////////////////////////////////////////
	// Host model
	//////////////////////////////////////////////////

	task automatic reportValue(input string what);
		$display("[FAIL] %0t %s", $time, what);
		valueErrors++;
	endtask

	// Poll on falling edges until dataReq reaches level
	task automatic waitReq(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge ReadClock);
			cycles++;
		end while (dataReq !== level && cycles < WaitLimit);
		if (dataReq !== level) begin
			$display("Timeout: dataReq did not go to %b within %0d cycles", level, WaitLimit);
			timedOut = 1'b1;
		end
	endtask

	task automatic waitState(input captureStatePkg::captureState target);
		int cycles;
		cycles = 0;
		do begin
			@(negedge ReadClock);
			cycles++;
		end while (state !== target && cycles < WaitLimit);
		if (state !== target) begin
			$display("Timeout: state did not reach %0d within %0d cycles", target, WaitLimit);
			timedOut = 1'b1;
		end
	endtask

	// Random 0 to 7 cycles before an ack edge
	task automatic hostDelay();
		int cycles;
		cycles = $unsigned($random(seed)) % 8;
		repeat (cycles) @(negedge ReadClock);
	endtask

	task automatic pulseStrobe();
		@(negedge WriteClock);
		writeStrobe = 1'b1;
		strobeSent = 1'b1;
		@(negedge WriteClock);
		writeStrobe = 1'b0;
	endtask

	// One full four-phase cycle
	task automatic takeByte(output sampleFormatPkg::laneByte value);
		waitReq(1'b1);
		value = dataOut;
		if (timedOut) return;
		hostDelay();
		dataAck = 1'b1;
		waitReq(1'b0);
		hostDelay();
		dataAck = 1'b0;
	endtask

	// Strobe, take every byte, then confirm the return to Idle
	task automatic captureRun(input bit extraStrobes);
		sampleFormatPkg::laneByte got;
		sampleFormatPkg::laneByte expected;
		logic [7:0] groupBase;
		int startReqs;
		int i;
		bit extraSeen;
		startReqs = reqCount;
		extraSeen = 1'b0;
		pulseStrobe();
		// Extra strobe while filling
		if (extraStrobes) begin
			waitState(captureStatePkg::Filling);
			pulseStrobe();
		end
		for (i = 0; i < BytesPerCapture && !timedOut; i++) begin
			// Extra strobe while sending the second word
			if (extraStrobes && i == 6) pulseStrobe();
			takeByte(got);
			// Ramp starts at zero and steps by 4 so every group base is a multiple of 4
			if (i == 0) groupBase = {got[7:2], 2'b00};
			else if (i % 4 == 0) groupBase = groupBase + 8'd4;
			expected = groupBase + 8'(laneOffset(i % 4));
			byteValue: assert (timedOut || got == expected) else
				reportValue($sformatf("byte %0d is %02h, expected %02h", i, got, expected));
		end
		waitState(captureStatePkg::Idle);
		readyDropped: assert (timedOut || !dataReadyToSend) else
			reportValue("dataReadyToSend still high in Idle");
		repeat (QuietCycles) begin
			@(negedge ReadClock);
			extraSeen |= dataReq;
		end
		noExtraBytes: assert (!extraSeen) else
			reportValue("dataReq rose after the capture ended");
		byteCount: assert (timedOut || reqCount - startReqs == BytesPerCapture) else
			reportValue($sformatf("%0d bytes sent, expected %0d",
				reqCount - startReqs, BytesPerCapture));
	endtask

	task automatic endTest(input int number, input string name, input int errorsBefore);
		int found;
		found = valueErrors + protocolErrors - errorsBefore;
		testsRun++;
		if (found == 0 && !timedOut) begin
			$display("test %0d %s: ok", number, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: %0d errors", number, name, found);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int mark;
		int fullBefore;
		rstN = 1'b0;
		writeStrobe = 1'b0;
		dataAck = 1'b0;
		repeat (16) @(posedge ReadClock);
		@(negedge ReadClock);
		rstN = 1'b1;

		// Quiet window watched by idleUntilStrobe
		mark = valueErrors + protocolErrors;
		repeat (QuietCycles) @(negedge ReadClock);
		endTest(1, "reset values", mark);

		if (!timedOut) begin
			mark = valueErrors + protocolErrors;
			captureRun(1'b0);
			endTest(2, "single capture", mark);
		end
		// FIFO fills while the host is still slow on the first word
		if (!timedOut) begin
			mark = valueErrors + protocolErrors;
			fullBefore = fullCount;
			captureRun(1'b0);
			fullWentLow: assert (timedOut || fullCount > fullBefore) else
				reportValue("fifoNotFull never went low during the capture");
			endTest(3, "back-pressure", mark);
		end
		if (!timedOut) begin
			mark = valueErrors + protocolErrors;
			captureRun(1'b1);
			endTest(4, "strobes outside Idle", mark);
		end
		if (!timedOut) begin
			mark = valueErrors + protocolErrors;
			captureRun(1'b0);
			endTest(5, "capture after Idle", mark);
		end

		$display("Summary: %0d tests run, %0d failed, %0d value errors, %0d protocol errors",
			testsRun, testsFailed, valueErrors, protocolErrors);
		if (testsFailed == 0 && valueErrors + protocolErrors == 0 && !timedOut) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verilog/dataStorage.sv */
`timescale 1ns/100ps

// Capture buffer top, sampler on WriteClock, host on ReadClock
module dataStorage #(
	parameter int FifoDepth = 16,
	parameter int CaptureDepth = 16
) (
	// Sampler side
	input  logic                         WriteClock,
	input  sampleFormatPkg::sampleWord   dataIn,
	input  logic                         writeStrobe,
	// Host side
	input  logic                         ReadClock,
	input  logic                         rstN,
	input  logic                         dataAck,
	output sampleFormatPkg::laneByte     dataOut,
	output logic                         dataReq,
	output logic                         dataReadyToSend,
	output logic                         fifoNotFull,
	output captureStatePkg::captureState state
);

	// Write domain wires
	logic wrEn;
	logic wrRstN;
	logic wrFull;

	// Read domain wires
	logic rdEmpty;
	logic rdEn;
	logic wordDone;
	sampleFormatPkg::sampleWord rdData;

	captureControl #(
		.FifoDepth    (FifoDepth),
		.CaptureDepth (CaptureDepth)
	) u_captureControl (
		.WriteClock      (WriteClock),
		.ReadClock       (ReadClock),
		.rstN            (rstN),
		.writeStrobe     (writeStrobe),
		.wrEn            (wrEn),
		.wrRstN          (wrRstN),
		.wrFull          (wrFull),
		.wordDone        (wordDone),
		.dataReadyToSend (dataReadyToSend),
		.fifoNotFull     (fifoNotFull),
		.state           (state)
	);

	asyncFifo #(
		.FifoDepth (FifoDepth)
	) u_asyncFifo (
		.WriteClock (WriteClock),
		.wrRstN     (wrRstN),
		.wrEn       (wrEn),
		.wrData     (dataIn),
		.wrFull     (wrFull),
		.ReadClock  (ReadClock),
		.rstN       (rstN),
		.rdEn       (rdEn),
		.rdData     (rdData),
		.rdEmpty    (rdEmpty)
	);

	byteSerializer u_byteSerializer (
		.ReadClock (ReadClock),
		.rstN      (rstN),
		.rdEmpty   (rdEmpty),
		.rdData    (rdData),
		.rdEn      (rdEn),
		.dataOut   (dataOut),
		.dataReq   (dataReq),
		.dataAck   (dataAck),
		.wordDone  (wordDone)
	);

endmodule

/* verilog/byteSerializer.sv */
`timescale 1ns/100ps

// Pops words and sends them byte by byte over a four-phase req/ack
module byteSerializer (
	input  logic                       ReadClock,
	input  logic                       rstN,
	// FIFO side
	input  logic                       rdEmpty,
	input  sampleFormatPkg::sampleWord rdData,
	output logic                       rdEn,
	// Host side
	output sampleFormatPkg::laneByte   dataOut,
	output logic                       dataReq,
	input  logic                       dataAck,
	// To capture control
	output logic                       wordDone
);

	// Handshake phases
	typedef enum logic [1:0] {
		// Waiting for a word
		Load = 2'b00,
		// dataReq high until ack rises
		Request = 2'b01,
		// dataReq low until ack falls
		Release = 2'b10,
		// One-cycle word done pulse
		Finish = 2'b11
	} serialPhase;

	serialPhase phase;
	sampleFormatPkg::sampleWord wordReg;
	sampleFormatPkg::laneIndex laneIdx;
	logic lastLane;

	// Pop as soon as a word shows up
	assign rdEn = (phase == Load) && !rdEmpty;
	assign lastLane = (laneIdx == sampleFormatPkg::LastLane);

	always_ff @(posedge ReadClock) begin
		if (!rstN) begin
			phase <= Load;
			laneIdx <= sampleFormatPkg::FirstLane;
		end else begin
			case (phase)
				Load:
					if (!rdEmpty) begin
						laneIdx <= sampleFormatPkg::FirstLane;
						phase <= Request;
					end
				Request:
					// Host took the byte
					if (dataAck) phase <= Release;
				Release:
					// Ack low again, next byte or end of word
					if (!dataAck) begin
						if (lastLane) begin
							phase <= Finish;
						end else begin
							laneIdx <= laneIdx + 1'b1;
							phase <= Request;
						end
					end
				default:
					phase <= Load;
			endcase
		end
	end

	// Word payload, no reset
	always_ff @(posedge ReadClock) begin
		if (rdEn) begin
			wordReg <= rdData;
		end
	end

	// Lowest lane first, DQD DQ DID DI
	assign dataOut = sampleFormatPkg::pickLane(wordReg, laneIdx);
	assign dataReq = (phase == Request);
	assign wordDone = (phase == Finish);

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Host may sample dataOut any time dataReq is up
	stableWhileReq: assert property (
		@(posedge ReadClock) disable iff (!rstN)
		dataReq && $past(dataReq) |-> $stable(dataOut)
	) else $error("byteSerializer: dataOut changed while dataReq high");

endmodule

/* verilog/captureControl.sv */
`timescale 1ns/100ps

// Arms a capture, counts written words, tracks the capture state
module captureControl #(
	parameter int FifoDepth = 16,
	parameter int CaptureDepth = 16
) (
	input  logic                         WriteClock,
	input  logic                         ReadClock,
	input  logic                         rstN,
	// Write side
	input  logic                         writeStrobe,
	output logic                         wrEn,
	output logic                         wrRstN,
	input  logic                         wrFull,
	// Read side
	input  logic                         wordDone,
	output logic                         dataReadyToSend,
	output logic                         fifoNotFull,
	output captureStatePkg::captureState state
);

	localparam int CountWidth = $clog2(CaptureDepth + 1);
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(CaptureDepth - 1);

	// Write domain
	logic [1:0]            wrRstSync;
	logic [1:0]            idleSync;
	logic                  capturing;
	logic [CountWidth-1:0] wordCount;
	// Arm and done flip once per capture
	logic                  armToggle;
	logic                  doneToggle;
	// Release tracking, read side must leave Idle and come back
	logic                  waitLeave;
	logic                  waitReturn;

	// Read domain
	logic [1:0]            armSync;
	logic [1:0]            doneSync;
	logic [1:0]            fullSync;
	logic                  armSeen;
	logic                  doneSeen;
	logic                  idleFlag;
	logic [CountWidth-1:0] doneCount;
	logic                  lastWord;
	captureStatePkg::captureState stateReg;
	captureStatePkg::captureState stateNext;

	//////////////////////////////////////////////////
	// Write clock domain
	//////////////////////////////////////////////////

	// Reset re-timed into WriteClock
	always_ff @(posedge WriteClock) begin
		wrRstSync <= {wrRstSync[0], rstN};
	end
	assign wrRstN = wrRstSync[1];

	always_ff @(posedge WriteClock) begin
		if (!wrRstN) begin
			idleSync <= 2'b11;
			capturing <= 1'b0;
			wordCount <= '0;
			armToggle <= 1'b0;
			doneToggle <= 1'b0;
			waitLeave <= 1'b0;
			waitReturn <= 1'b0;
		end else begin
			idleSync <= {idleSync[0], idleFlag};
			// Read side has picked up the capture
			if (waitLeave && !idleSync[1]) begin
				waitLeave <= 1'b0;
				waitReturn <= 1'b1;
			end
			// Read side back in Idle, write side free again
			if (waitReturn && idleSync[1]) begin
				waitReturn <= 1'b0;
			end
			if (capturing) begin
				wordCount <= wordCount + 1'b1;
				if (wordCount == LastCount) begin
					capturing <= 1'b0;
					doneToggle <= ~doneToggle;
				end
			end else if (writeStrobe && !waitLeave && !waitReturn) begin
				// Strobes outside Idle fall through here
				capturing <= 1'b1;
				wordCount <= '0;
				armToggle <= ~armToggle;
				waitLeave <= 1'b1;
			end
		end
	end

	// Push on exactly CaptureDepth edges after the strobe
	assign wrEn = capturing;

	//////////////////////////////////////////////////
	// Read clock domain
	//////////////////////////////////////////////////

	assign lastWord = (doneCount == LastCount);

	always_comb begin
		stateNext = stateReg;
		case (stateReg)
			captureStatePkg::Idle:
				if (armSync[1] != armSeen) stateNext = captureStatePkg::Filling;
			captureStatePkg::Filling:
				if (doneSync[1] != doneSeen) stateNext = captureStatePkg::Draining;
			captureStatePkg::Draining:
				if (wordDone) begin
					stateNext = lastWord ? captureStatePkg::Idle : captureStatePkg::Sending;
				end
			captureStatePkg::Sending:
				if (wordDone && lastWord) stateNext = captureStatePkg::Idle;
			default:
				stateNext = captureStatePkg::Idle;
		endcase
	end

	always_ff @(posedge ReadClock) begin
		if (!rstN) begin
			armSync <= '0;
			doneSync <= '0;
			fullSync <= '0;
			armSeen <= 1'b0;
			doneSeen <= 1'b0;
			idleFlag <= 1'b1;
			doneCount <= '0;
			stateReg <= captureStatePkg::Idle;
		end else begin
			armSync <= {armSync[0], armToggle};
			doneSync <= {doneSync[0], doneToggle};
			fullSync <= {fullSync[0], wrFull};
			idleFlag <= (stateNext == captureStatePkg::Idle);
			stateReg <= stateNext;
			// Word count restarts with each capture
			if (stateReg == captureStatePkg::Idle) begin
				armSeen <= armSync[1];
				doneCount <= '0;
			end else if (wordDone) begin
				doneCount <= doneCount + 1'b1;
			end
			if (stateReg == captureStatePkg::Filling) doneSeen <= doneSync[1];
		end
	end

	assign state = stateReg;
	assign dataReadyToSend = captureStatePkg::isReady(stateReg);
	assign fifoNotFull = !fullSync[1];

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// One capture must fit in the FIFO
	depthFits: assert property (
		@(posedge ReadClock) CaptureDepth <= FifoDepth
	) else $error("captureControl: CaptureDepth exceeds FifoDepth");

	// Serializer only finishes words belonging to a capture
	noWordInIdle: assert property (
		@(posedge ReadClock) disable iff (!rstN)
		wordDone |-> stateReg != captureStatePkg::Idle
	) else $error("captureControl: wordDone while Idle");

endmodule

/* verilog/asyncFifo.sv */
`timescale 1ns/100ps

// Dual-clock FIFO, Gray pointers cross between the two clocks
module asyncFifo #(
	parameter int FifoDepth = 16
) (
	// Write side
	input  logic                       WriteClock,
	input  logic                       wrRstN,
	input  logic                       wrEn,
	input  sampleFormatPkg::sampleWord wrData,
	output logic                       wrFull,
	// Read side
	input  logic                       ReadClock,
	input  logic                       rstN,
	input  logic                       rdEn,
	output sampleFormatPkg::sampleWord rdData,
	output logic                       rdEmpty
);

	localparam int AddrWidth = $clog2(FifoDepth);
	// One extra bit tells a full FIFO from an empty one
	localparam int PtrWidth = AddrWidth + 1;
	// Full when the top two Gray bits differ and the rest match
	localparam logic [PtrWidth-1:0] FullMask = PtrWidth'(3) << (AddrWidth - 1);

	// Storage
	sampleFormatPkg::sampleWord mem [FifoDepth];

	// Write pointers
	logic [PtrWidth-1:0] wrBin;
	logic [PtrWidth-1:0] wrBinNext;
	logic [PtrWidth-1:0] wrGray;
	logic [PtrWidth-1:0] wrGrayNext;
	logic                wrPush;

	// Read pointers
	logic [PtrWidth-1:0] rdBin;
	logic [PtrWidth-1:0] rdBinNext;
	logic [PtrWidth-1:0] rdGray;
	logic [PtrWidth-1:0] rdGrayNext;
	logic                rdPop;

	// Synchronizer stages, named after the clock they land in
	logic [PtrWidth-1:0] rdGrayWr1;
	logic [PtrWidth-1:0] rdGrayWr2;
	logic [PtrWidth-1:0] wrGrayRd1;
	logic [PtrWidth-1:0] wrGrayRd2;

	//////////////////////////////////////////////////
	// Write clock domain
	//////////////////////////////////////////////////

	assign wrPush = wrEn && !wrFull;
	assign wrBinNext = wrBin + PtrWidth'(wrPush);
	assign wrGrayNext = wrBinNext ^ (wrBinNext >> 1);
	// Compared against the delayed read pointer, so full is pessimistic
	assign wrFull = (wrGray == (rdGrayWr2 ^ FullMask));

	always_ff @(posedge WriteClock) begin
		if (!wrRstN) begin
			wrBin <= '0;
			wrGray <= '0;
			rdGrayWr1 <= '0;
			rdGrayWr2 <= '0;
		end else begin
			wrBin <= wrBinNext;
			wrGray <= wrGrayNext;
			// Two-flop sync of read pointer
			rdGrayWr1 <= rdGray;
			rdGrayWr2 <= rdGrayWr1;
		end
	end

	// Memory indexed by binary pointer
	always_ff @(posedge WriteClock) begin
		if (wrPush) begin
			mem[wrBin[AddrWidth-1:0]] <= wrData;
		end
	end

	//////////////////////////////////////////////////
	// Read clock domain
	//////////////////////////////////////////////////

	assign rdPop = rdEn && !rdEmpty;
	assign rdBinNext = rdBin + PtrWidth'(rdPop);
	assign rdGrayNext = rdBinNext ^ (rdBinNext >> 1);
	// Empty on match with the delayed write pointer
	assign rdEmpty = (rdGray == wrGrayRd2);

	// Head word, valid whenever not empty
	assign rdData = mem[rdBin[AddrWidth-1:0]];

	always_ff @(posedge ReadClock) begin
		if (!rstN) begin
			rdBin <= '0;
			rdGray <= '0;
			wrGrayRd1 <= '0;
			wrGrayRd2 <= '0;
		end else begin
			rdBin <= rdBinNext;
			rdGray <= rdGrayNext;
			// Two-flop sync of write pointer
			wrGrayRd1 <= wrGray;
			wrGrayRd2 <= wrGrayRd1;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Capture control must never push into a full FIFO
	noWriteWhenFull: assert property (
		@(posedge WriteClock) disable iff (!wrRstN) wrEn |-> !wrFull
	) else $error("asyncFifo: write while full");

	// Serializer must never pop an empty FIFO
	noReadWhenEmpty: assert property (
		@(posedge ReadClock) disable iff (!rstN) rdEn |-> !rdEmpty
	) else $error("asyncFifo: read while empty");

endmodule

/* verilog/captureStatePkg.sv */
// Capture states as seen on the state port
package captureStatePkg;

	// Encoding is fixed, the host decodes these two bits
	typedef enum logic [1:0] {
		// Waiting for a strobe
		Idle = 2'b00,
		// Words going into the FIFO
		Filling = 2'b01,
		// Capture finished, bytes waiting
		Draining = 2'b10,
		// Host handshake running
		Sending = 2'b11
	} captureState;

	// Bytes are ready for the host in these two states
	function automatic logic isReady(input captureState state);
		return (state == Draining) || (state == Sending);
	endfunction

endpackage

/* verilog/sampleFormatPkg.sv */
// Layout of one sampler word and the lane order used on output
package sampleFormatPkg;

	// Bits per lane and lanes per word
	localparam int LaneWidth = 8;
	localparam int LaneCount = 4;

	// One lane, also the width of the host byte port
	typedef logic [LaneWidth-1:0] laneByte;

	// Packed word {DI, DID, DQ, DQD}
	// DQD sits in lane 0, DQ in lane 1, DID in lane 2, DI in lane 3
	typedef logic [LaneCount*LaneWidth-1:0] sampleWord;

	// Lane index, walked upward so the lowest lane leaves first
	typedef logic [$clog2(LaneCount)-1:0] laneIndex;
	localparam laneIndex FirstLane = '0;
	localparam laneIndex LastLane = laneIndex'(LaneCount - 1);

	// Pull one lane out of a word
	function automatic laneByte pickLane(input sampleWord word, input laneIndex lane);
		return word[lane*LaneWidth +: LaneWidth];
	endfunction

endpackage
